//--- flist.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/issue_port.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/barrel_shifter.sv
hdl/execute_stage.sv
hdl/dp_core.sv
testbench/tb_dp_core.sv

//--- Makefile
TOP = tb_dp_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_dp_core.sv
`timescale 1ns/100ps

`include "core_consts.svh"

module tb_dp_core
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int TIMEOUT     = 20;

    logic        clk;
    logic        reset;
    logic        instr_req;
    instr_word_t instr;
    logic        instr_ack;
    logic        wb_valid;
    reg_addr_t   wb_reg;
    word_t       wb_data;

    logic [31:0] lfsr;
    word_t       model_regs [`NUM_REGS];
    reg_addr_t   exp_reg_q [$];
    word_t       exp_data_q [$];
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;

    dp_core dp_core_i (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers

    // feedback taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic cmd_supported(input logic [3:0] c);
        return c inside {cmd_and, cmd_eor, cmd_sub, cmd_add, cmd_orr, cmd_mov};
    endfunction

    function automatic logic [3:0] pick_cmd(input int idx);
        case (idx)
            0:       return cmd_and;
            1:       return cmd_eor;
            2:       return cmd_sub;
            3:       return cmd_add;
            4:       return cmd_orr;
            default: return cmd_mov;
        endcase
    endfunction

    // cond field fixed to always and S bit clear
    function automatic instr_word_t make_instr(input logic [1:0] op, input logic imm,
        input logic [3:0] cmd, input reg_addr_t rn, input reg_addr_t rd,
        input logic [11:0] op2);
        return {4'he, op, imm, cmd, 1'b0, rn, rd, op2};
    endfunction

    function automatic instr_word_t random_dp(input logic imm_allowed);
        logic [3:0] cmd;
        logic       imm;
        cmd = pick_cmd(int'(rand_bits(3)) % 6);
        imm = 1'(rand_bits(1)) & imm_allowed;
        return make_instr(2'b00, imm, cmd, reg_addr_t'(rand_bits(4)),
                          reg_addr_t'(rand_bits(4)), 12'(rand_bits(12)));
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic word_t shift_ref(input word_t v, input shift_kind_t k, input shamt_t s);
        case (k)
            sh_lsl:  return v << s;
            sh_lsr:  return v >> s;
            sh_asr:  return (v >> s) | (v[31] ? ~(32'hffff_ffff >> s) : 32'd0);
            default: return (s == 0) ? v : ((v >> s) | (v << (32 - s)));
        endcase
    endfunction

    task automatic model_issue(input instr_word_t w);
        logic [3:0] cmd;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        cmd = w[`CMD_HI:`CMD_LO];
        rd  = w[`RD_HI:`RD_LO];
        a   = model_regs[w[`RN_HI:`RN_LO]];
        if (w[`I_HI]) begin
            b = word_t'(w[`IMM_HI:`IMM_LO]);
        end else begin
            b = shift_ref(model_regs[w[`RM_HI:`RM_LO]], shift_kind_t'(w[`SH_HI:`SH_LO]),
                          w[`SHAMT_HI:`SHAMT_LO]);
        end
        case (cmd)
            cmd_and: res = a & b;
            cmd_eor: res = a ^ b;
            cmd_sub: res = a - b;
            cmd_add: res = a + b;
            cmd_orr: res = a | b;
            default: res = b;
        endcase
        // no-ops leave the model untouched
        if (w[`OP_HI:`OP_LO] == 2'b00 && cmd_supported(cmd)) begin
            model_regs[rd] = res;
            exp_reg_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks and waits

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run();
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level, output int n);
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end while (instr_ack !== level && n < TIMEOUT);
        if (instr_ack !== level) begin
            $display("timeout: instr_ack never went to %0d", level);
            abort_run();
        end
    endtask

    // one four-phase transfer with gap and hold counted in cycles
    task automatic issue(input instr_word_t w, input int gap, input int hold);
        int n;
        for (int k = 0; k < gap; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (instr_ack !== 1'b0) begin
                $display("instr_ack went high with no request pending");
                errors++;
            end
        end
        model_issue(w);
        instr     = w;
        instr_req = 1'b1;
        wait_ack(1'b1, n);
        if (n != 1) begin
            $display("instr_ack rose %0d cycles after instr_req instead of one", n);
            errors++;
        end
        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (instr_ack !== 1'b1) begin
                $display("instr_ack fell while instr_req was still high");
                errors++;
            end
        end
        instr_req = 1'b0;
        wait_ack(1'b0, n);
        if (n != 1) begin
            $display("instr_ack fell %0d cycles after instr_req dropped instead of one", n);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (exp_reg_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            n++;
        end
        if (exp_reg_q.size() != 0) begin
            $display("timeout: %0d results never came out in test %s", exp_reg_q.size(), name);
            abort_run();
        end
        // a stray write would be out of the pipeline by now
        repeat (4) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    // result port sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && wb_valid) begin
            if (exp_reg_q.size() == 0) begin
                $display("write to r%0d arrived with no result pending", wb_reg);
                errors++;
            end else begin
                check_reg("wb_reg", wb_reg, exp_reg_q.pop_front());
                check_word("wb_data", wb_data, exp_data_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        reg_addr_t  prev_rd;
        logic [3:0] cmd;
        int         kind;
        reset           = 1'b1;
        instr_req       = 1'b0;
        instr           = '0;
        lfsr            = 32'he7d5bb0f;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end

        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (instr_ack !== 1'b0 || wb_valid !== 1'b0) begin
                $display("instr_ack or wb_valid was high during reset");
                errors++;
            end
        end
        reset = 1'b0;
        // every register reads back zero
        for (int r = 0; r < `NUM_REGS; r++) begin
            issue(make_instr(2'b00, 1'b0, cmd_mov, '0, reg_addr_t'(r), {8'h00, 4'(r)}), 1, 0);
        end
        finish_test("reset");

        for (int k = 0; k < 30; k++) begin
            issue(random_dp(1'b1), int'(rand_bits(3)) % 6, int'(rand_bits(2)) % 3);
        end
        finish_test("handshake");

        for (int k = 0; k < 200; k++) begin
            issue(random_dp(1'b1), int'(rand_bits(1)), 0);
        end
        finish_test("data processing");

        for (int k = 0; k < 100; k++) begin
            issue(random_dp(1'b0), 0, 0);
        end
        finish_test("shifts");

        // each link reads the previous rd at minimum spacing
        for (int c = 0; c < 20; c++) begin
            prev_rd = reg_addr_t'(rand_bits(4));
            for (int k = 0; k < 6; k++) begin
                cmd = pick_cmd(int'(rand_bits(3)) % 6);
                instr = make_instr(2'b00, 1'(rand_bits(1)), cmd, prev_rd,
                                   reg_addr_t'(rand_bits(4)),
                                   {8'(rand_bits(8)),
                                    rand_bits(1) ? prev_rd : reg_addr_t'(rand_bits(4))});
                prev_rd = instr[`RD_HI:`RD_LO];
                issue(instr, 0, 0);
            end
        end
        finish_test("dependencies");

        for (int k = 0; k < 40; k++) begin
            kind = int'(rand_bits(2)) % 3;
            instr = random_dp(1'b1);
            if (kind == 0) begin
                cmd = 4'(rand_bits(4));
                while (cmd_supported(cmd)) begin
                    cmd = 4'(rand_bits(4));
                end
                instr[`CMD_HI:`CMD_LO] = cmd;
            end else if (kind == 1) begin
                instr[`OP_HI:`OP_LO] = 2'(1 + int'(rand_bits(2)) % 3);
            end
            issue(instr, 0, 0);
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            issue(make_instr(2'b00, 1'b0, cmd_mov, '0, reg_addr_t'(r), {8'h00, 4'(r)}), 0, 0);
        end
        finish_test("non-writing");

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/dp_core.sv
`timescale 1ns/100ps

module dp_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_req,
    input  instr_word_t instr,
    output logic        instr_ack,
    output logic        wb_valid,
    output reg_addr_t   wb_reg,
    output word_t       wb_data
);

    // decode stage
    instr_word_t instr_d;
    logic        valid_d;
    reg_addr_t   rn_addr;
    reg_addr_t   rm_addr;
    reg_addr_t   rd_addr;
    alu_op_t     alu_op;
    logic        use_imm;
    word_t       imm_word;
    shift_kind_t shift_kind;
    shamt_t      shamt;
    logic        writes_reg;
    word_t       rn_data;
    word_t       rm_data;

    issue_port issue_port_i (
        .clk       (clk),
        .reset     (reset),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .instr_d   (instr_d),
        .valid_d   (valid_d)
    );

    instr_decoder instr_decoder_i (
        .instr_d    (instr_d),
        .valid_d    (valid_d),
        .rn_addr    (rn_addr),
        .rm_addr    (rm_addr),
        .rd_addr    (rd_addr),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm_word   (imm_word),
        .shift_kind (shift_kind),
        .shamt      (shamt),
        .writes_reg (writes_reg)
    );

    // result port doubles as the write port
    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rn_addr  (rn_addr),
        .rm_addr  (rm_addr),
        .rn_data  (rn_data),
        .rm_data  (rm_data),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .reset      (reset),
        .writes_reg (writes_reg),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm_word   (imm_word),
        .shift_kind (shift_kind),
        .shamt      (shamt),
        .rd_addr    (rd_addr),
        .rn_data    (rn_data),
        .rm_data    (rm_data),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        writes_reg,
    input  alu_op_t     alu_op,
    input  logic        use_imm,
    input  word_t       imm_word,
    input  shift_kind_t shift_kind,
    input  shamt_t      shamt,
    input  reg_addr_t   rd_addr,
    input  word_t       rn_data,
    input  word_t       rm_data,
    output logic        wb_valid,
    output reg_addr_t   wb_reg,
    output word_t       wb_data
);

    logic        ex_valid;
    alu_op_t     ex_op;
    logic        ex_use_imm;
    word_t       ex_imm;
    shift_kind_t ex_kind;
    shamt_t      ex_shamt;
    reg_addr_t   ex_rd;
    word_t       ex_rn;
    word_t       ex_rm;

    word_t       rm_shifted;
    word_t       op_b;
    word_t       alu_result;

    ////////////////////////////////////////////////////////////
    // execute register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= writes_reg;
        end
    end

    always_ff @(posedge clk) begin
        ex_op      <= alu_op;
        ex_use_imm <= use_imm;
        ex_imm     <= imm_word;
        ex_kind    <= shift_kind;
        ex_shamt   <= shamt;
        ex_rd      <= rd_addr;
        ex_rn      <= rn_data;
        ex_rm      <= rm_data;
    end

    ////////////////////////////////////////////////////////////
    // operand b and alu

    barrel_shifter barrel_shifter_i (
        .operand    (ex_rm),
        .shift_kind (ex_kind),
        .shamt      (ex_shamt),
        .shifted    (rm_shifted)
    );

    assign op_b = ex_use_imm ? ex_imm : rm_shifted;

    always_comb begin
        case (ex_op)
            alu_and: alu_result = ex_rn & op_b;
            alu_eor: alu_result = ex_rn ^ op_b;
            alu_sub: alu_result = ex_rn - op_b;
            alu_add: alu_result = ex_rn + op_b;
            alu_orr: alu_result = ex_rn | op_b;
            // mov
            default: alu_result = op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // result register, also the write port

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= ex_rd;
        wb_data <= alu_result;
    end

endmodule

//--- hdl/barrel_shifter.sv
`timescale 1ns/100ps

`include "core_consts.svh"

module barrel_shifter
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t       operand,
    input  shift_kind_t shift_kind,
    input  shamt_t      shamt,
    output word_t       shifted
);

    logic [2*`WORD_W-1:0] rot_pair;
    word_t                rotated;
    word_t                arith;

    // rotate by shifting a doubled copy, low half is the result
    assign rot_pair = {operand, operand} >> shamt;
    assign rotated  = rot_pair[`WORD_W-1:0];

    // sign bit fills from the left
    assign arith = $signed(operand) >>> shamt;

    ////////////////////////////////////////////////////////////
    // kind select

    always_comb begin
        case (shift_kind)
            sh_lsl: begin
                shifted = operand << shamt;
            end
            sh_lsr: begin
                shifted = operand >> shamt;
            end
            sh_asr: begin
                shifted = arith;
            end
            default: begin
                // ror, amount 0 leaves the operand as is
                shifted = rotated;
            end
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps

`include "core_consts.svh"

module reg_file
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rn_addr,
    input  reg_addr_t rm_addr,
    output word_t     rn_data,
    output word_t     rm_data,
    input  logic      wb_valid,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // write-through bypass, a same-cycle write wins over the stored word
    assign rn_data = (wb_valid && (wb_reg == rn_addr)) ? wb_data : regs[rn_addr];
    assign rm_data = (wb_valid && (wb_reg == rm_addr)) ? wb_data : regs[rm_addr];

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/100ps

`include "core_consts.svh"

module instr_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  instr_word_t instr_d,
    input  logic        valid_d,
    output reg_addr_t   rn_addr,
    output reg_addr_t   rm_addr,
    output reg_addr_t   rd_addr,
    output alu_op_t     alu_op,
    output logic        use_imm,
    output word_t       imm_word,
    output shift_kind_t shift_kind,
    output shamt_t      shamt,
    output logic        writes_reg
);

    logic [1:0] op;
    dp_cmd_t    cmd;
    imm8_t      imm8;
    logic       cmd_known;

    // field extraction
    assign op      = instr_d[`OP_HI:`OP_LO];
    assign cmd     = dp_cmd_t'(instr_d[`CMD_HI:`CMD_LO]);
    assign imm8    = instr_d[`IMM_HI:`IMM_LO];
    assign rn_addr = instr_d[`RN_HI:`RN_LO];
    assign rd_addr = instr_d[`RD_HI:`RD_LO];
    assign rm_addr = instr_d[`RM_HI:`RM_LO];
    assign use_imm = instr_d[`I_HI];

    // shift fields, ignored by execute when use_imm is set
    assign shift_kind = shift_kind_t'(instr_d[`SH_HI:`SH_LO]);
    assign shamt      = instr_d[`SHAMT_HI:`SHAMT_LO];

    // zero-extended byte immediate
    assign imm_word = {{(`WORD_W - `IMM_W){1'b0}}, imm8};

    ////////////////////////////////////////////////////////////
    // command to alu operation

    always_comb begin
        cmd_known = 1'b1;
        case (cmd)
            cmd_and: alu_op = alu_and;
            cmd_eor: alu_op = alu_eor;
            cmd_sub: alu_op = alu_sub;
            cmd_add: alu_op = alu_add;
            cmd_orr: alu_op = alu_orr;
            cmd_mov: alu_op = alu_pass_b;
            default: begin
                // anything else becomes a no-op
                alu_op    = alu_pass_b;
                cmd_known = 1'b0;
            end
        endcase
    end

    // only valid data-processing words with a known command write back
    assign writes_reg = valid_d && (op == `OP_DP) && cmd_known;

endmodule

//--- hdl/issue_port.sv
`timescale 1ns/100ps

module issue_port
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_req,
    input  instr_word_t instr,
    output logic        instr_ack,
    output instr_word_t instr_d,
    output logic        valid_d
);

    issue_state_t state;
    logic         capture;

    // req seen while idle, take the word on this edge
    assign capture = (state == wait_req) && instr_req;

    ////////////////////////////////////////////////////////////
    // handshake FSM

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= wait_req;
            valid_d <= 1'b0;
        end else begin
            valid_d <= capture;
            case (state)
                wait_req: begin
                    if (instr_req) begin
                        state <= hold_ack;
                    end
                end
                hold_ack: begin
                    // release once the requester drops req
                    if (!instr_req) begin
                        state <= wait_req;
                    end
                end
                default: state <= wait_req;
            endcase
        end
    end

    assign instr_ack = (state == hold_ack);

    ////////////////////////////////////////////////////////////
    // decode-stage instruction register

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_d <= instr;
        end
    end

endmodule

//--- hdl/pipe_pkg.sv
`include "core_consts.svh"

package pipe_pkg;

    // data word through the datapath
    typedef logic [`WORD_W-1:0] word_t;

    // register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // decoded alu operation
    typedef enum logic [2:0] {
        alu_and    = 3'd0,
        alu_eor    = 3'd1,
        alu_sub    = 3'd2,
        alu_add    = 3'd3,
        alu_orr    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_t;

    // four-phase handshake on the instruction port
    typedef enum logic {
        wait_req = 1'b0,
        hold_ack = 1'b1
    } issue_state_t;

endpackage

//--- hdl/isa_pkg.sv
`include "core_consts.svh"

package isa_pkg;

    // full instruction word as handed in on the port
    typedef logic [`WORD_W-1:0] instr_word_t;

    // command field, only the supported codes are named
    typedef enum logic [3:0] {
        cmd_and = 4'b0000,
        cmd_eor = 4'b0001,
        cmd_sub = 4'b0010,
        cmd_add = 4'b0100,
        cmd_orr = 4'b1100,
        cmd_mov = 4'b1101
    } dp_cmd_t;

    // shift kind field, bits 6:5
    typedef enum logic [1:0] {
        sh_lsl = 2'b00,
        sh_lsr = 2'b01,
        sh_asr = 2'b10,
        sh_ror = 2'b11
    } shift_kind_t;

    // immediate shift amount, bits 11:7
    typedef logic [`SHAMT_W-1:0] shamt_t;

    // low byte immediate, bits 7:0
    typedef logic [`IMM_W-1:0] imm8_t;

endpackage

//--- include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  4
`define NUM_REGS    16
`define IMM_W       8
`define SHAMT_W     5

// instruction field positions
`define OP_HI       27
`define OP_LO       26
`define I_HI        25
`define I_LO        25
`define CMD_HI      24
`define CMD_LO      21
`define RN_HI       19
`define RN_LO       16
`define RD_HI       15
`define RD_LO       12
`define SHAMT_HI    11
`define SHAMT_LO    7
`define SH_HI       6
`define SH_LO       5
`define RM_HI       3
`define RM_LO       0
`define IMM_HI      7
`define IMM_LO      0

// op field value for data processing
`define OP_DP       2'b00

`endif
